//--- rtl/SchedulerPkg.sv
/*
 * Scheduler package
 * Default sizes, tag and active-list pointer types, selector states,
 * the per-entry op record and the circular flush-range check
 */
package SchedulerPkg;

    localparam int QUEUE_ENTRIES_DEFAULT = 8;
    localparam int WAKEUP_LATENCY_DEFAULT = 2;
    localparam int AL_PTR_WIDTH = 4;
    localparam int TAG_WIDTH = 8;

    typedef logic [AL_PTR_WIDTH-1:0] ActiveListPtr;
    typedef logic [TAG_WIDTH-1:0] OpTag;

    typedef enum logic [1:0] {
        selIdle,
        selRun,
        selStalled
    } SelState;

    // Payload held per issue-queue entry
    typedef struct packed {
        OpTag tag;
        ActiveListPtr alPtr;
    } IssueOp;

    // Head inclusive, tail exclusive, may wrap around
    // Equal head and tail give an empty range
    function automatic logic InRange(
        ActiveListPtr ptr,
        ActiveListPtr head,
        ActiveListPtr tail
    );
        if (head <= tail) begin
            return (ptr >= head) && (ptr < tail);
        end
        return (ptr >= head) || (ptr < tail);
    endfunction

endpackage

//--- rtl/WakeupSelectIF.sv
/*
 * Selected-op channel from the issue selector
 * into the wakeup pipeline register
 */
interface WakeupSelectIF #(
    parameter int QUEUE_ENTRIES = SchedulerPkg::QUEUE_ENTRIES_DEFAULT
);

    logic selected;
    logic [$clog2(QUEUE_ENTRIES)-1:0] selectedPtr;
    // One-hot producer column of the selected entry
    logic [QUEUE_ENTRIES-1:0] selectedVector;
    SchedulerPkg::ActiveListPtr selectedAlPtr;

    modport selector (
        output selected,
        output selectedPtr,
        output selectedVector,
        output selectedAlPtr
    );

    modport pipeline (
        input selected,
        input selectedPtr,
        input selectedVector,
        input selectedAlPtr
    );

endinterface

//--- rtl/WakeupReleaseIF.sv
/*
 * Wakeup and release channel between the wakeup
 * pipeline register and the issue queue
 */
interface WakeupReleaseIF #(
    parameter int QUEUE_ENTRIES = SchedulerPkg::QUEUE_ENTRIES_DEFAULT
);

    logic wakeup;
    logic [QUEUE_ENTRIES-1:0] wakeupVector;
    logic releaseEntry;
    logic [$clog2(QUEUE_ENTRIES)-1:0] releasePtr;
    // Entries hit by the current flush, driven back by the queue
    logic [QUEUE_ENTRIES-1:0] flushIqEntry;

    modport pipeline (
        output wakeup,
        output wakeupVector,
        output releaseEntry,
        output releasePtr,
        input flushIqEntry
    );

    modport queue (
        input wakeup,
        input wakeupVector,
        input releaseEntry,
        input releasePtr,
        output flushIqEntry
    );

endinterface

//--- rtl/IssueSelector.sv
/*
 * Single-lane issue selector
 * Lowest-index ready entry, gated by the selector FSM
 */
module IssueSelector #(
    parameter int QUEUE_ENTRIES = SchedulerPkg::QUEUE_ENTRIES_DEFAULT
) (
    input logic clk,
    input logic arstN,
    input logic stall,
    input logic [QUEUE_ENTRIES-1:0] readyVector,
    input SchedulerPkg::ActiveListPtr entryAlPtr [QUEUE_ENTRIES],
    WakeupSelectIF.selector sel,
    input logic queueEmpty
);

    localparam int INDEX_WIDTH = $clog2(QUEUE_ENTRIES);

    SchedulerPkg::SelState selState;
    SchedulerPkg::SelState nextState;
    logic anyReady;
    logic [INDEX_WIDTH-1:0] pickPtr;

    always_comb begin
        nextState = selState;
        case (selState)
            SchedulerPkg::selIdle: begin
                if (stall) begin
                    nextState = SchedulerPkg::selStalled;
                end else if (!queueEmpty) begin
                    nextState = SchedulerPkg::selRun;
                end
            end
            SchedulerPkg::selRun: begin
                if (stall) begin
                    nextState = SchedulerPkg::selStalled;
                end else if (queueEmpty) begin
                    nextState = SchedulerPkg::selIdle;
                end
            end
            default: begin
                if (!stall) begin
                    nextState = queueEmpty ? SchedulerPkg::selIdle : SchedulerPkg::selRun;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            selState <= SchedulerPkg::selIdle;
        end else begin
            selState <= nextState;
        end
    end

    // Priority encoder, lowest index wins
    always_comb begin
        anyReady = 1'b0;
        pickPtr = '0;
        for (int i = 0; i < QUEUE_ENTRIES; i++) begin
            if (readyVector[i] && !anyReady) begin
                anyReady = 1'b1;
                pickPtr = INDEX_WIDTH'(i);
            end
        end
    end

    // No pick on any cycle that leads into the stalled state
    assign sel.selected = anyReady && (nextState != SchedulerPkg::selStalled);
    assign sel.selectedPtr = pickPtr;
    assign sel.selectedVector = QUEUE_ENTRIES'(1) << pickPtr;
    assign sel.selectedAlPtr = entryAlPtr[pickPtr];

endmodule

//--- rtl/WakeupPipelineRegister.sv
/*
 * Wakeup pipeline register
 * Delays issued ops by WAKEUP_LATENCY stages, drops flushed ops on entry,
 * suppresses wakeups of in-flight ops in a ranged flush, drives wakeup and release
 */
module WakeupPipelineRegister #(
    parameter int QUEUE_ENTRIES = SchedulerPkg::QUEUE_ENTRIES_DEFAULT,
    parameter int WAKEUP_LATENCY = SchedulerPkg::WAKEUP_LATENCY_DEFAULT
) (
    input logic clk,
    input logic arstN,
    input logic stall,
    input logic flushValid,
    input logic flushAll,
    input SchedulerPkg::ActiveListPtr flushHeadPtr,
    input SchedulerPkg::ActiveListPtr flushTailPtr,
    WakeupSelectIF.pipeline sel,
    WakeupReleaseIF.pipeline rel,
    output logic flushedOpExist
);

    localparam int INDEX_WIDTH = $clog2(QUEUE_ENTRIES);
    localparam int COUNT_WIDTH = $clog2(WAKEUP_LATENCY + 1);

    typedef struct packed {
        logic [INDEX_WIDTH-1:0] ptr;
        logic [QUEUE_ENTRIES-1:0] depVector;
        SchedulerPkg::ActiveListPtr alPtr;
    } StageData;

    // Stage 0 is the exit, stage WAKEUP_LATENCY-1 the entry
    logic [WAKEUP_LATENCY-1:0] stageValid;
    StageData stageData [WAKEUP_LATENCY];
    logic nextValid;
    StageData nextData;

    logic [COUNT_WIDTH-1:0] flushCount;
    SchedulerPkg::ActiveListPtr rangeHead;
    SchedulerPkg::ActiveListPtr rangeTail;
    logic exitFlushed;
    logic exitRelease;

    always_comb begin
        // An op picked from an entry being flushed never enters
        nextValid = sel.selected && !rel.flushIqEntry[sel.selectedPtr];
        nextData.ptr = sel.selectedPtr;
        nextData.depVector = sel.selectedVector;
        nextData.alPtr = sel.selectedAlPtr;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            stageValid <= '0;
        end else if (flushValid && flushAll) begin
            stageValid <= '0;
        end else if (!stall) begin
            for (int j = 0; j < WAKEUP_LATENCY - 1; j++) begin
                stageValid[j] <= stageValid[j+1];
            end
            stageValid[WAKEUP_LATENCY-1] <= nextValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            for (int j = 0; j < WAKEUP_LATENCY - 1; j++) begin
                stageData[j] <= stageData[j+1];
            end
            stageData[WAKEUP_LATENCY-1] <= nextData;
        end
    end

    // Ops that may belong to a ranged flush leave within this many unstalled cycles
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            flushCount <= '0;
        end else if (flushValid && flushAll) begin
            flushCount <= '0;
        end else if (flushValid) begin
            flushCount <= COUNT_WIDTH'(WAKEUP_LATENCY);
        end else if (!stall && flushCount != '0) begin
            flushCount <= flushCount - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (flushValid && !flushAll) begin
            rangeHead <= flushHeadPtr;
            rangeTail <= flushTailPtr;
        end
    end

    assign exitFlushed = (flushCount != '0)
        && SchedulerPkg::InRange(stageData[0].alPtr, rangeHead, rangeTail);

    // Flushed ops still give back their entry
    assign exitRelease = stageValid[0] && !stall;

    assign rel.releaseEntry = exitRelease;
    assign rel.releasePtr = stageData[0].ptr;
    assign rel.wakeup = exitRelease && !exitFlushed;
    assign rel.wakeupVector = stageData[0].depVector;

    assign flushedOpExist = (flushCount != '0);

endmodule

//--- rtl/IssueQueue.sv
/*
 * Issue queue
 * Entry storage, lowest-free allocation, dependency matrix,
 * wakeup and release handling, ranged and full flush
 */
module IssueQueue #(
    parameter int QUEUE_ENTRIES = SchedulerPkg::QUEUE_ENTRIES_DEFAULT
) (
    input logic clk,
    input logic arstN,
    input logic dispatchValid,
    input SchedulerPkg::OpTag dispatchTag,
    input logic [QUEUE_ENTRIES-1:0] dispatchDepVector,
    input SchedulerPkg::ActiveListPtr dispatchAlPtr,
    input logic flushValid,
    input logic flushAll,
    input SchedulerPkg::ActiveListPtr flushHeadPtr,
    input SchedulerPkg::ActiveListPtr flushTailPtr,
    input logic selected,
    input logic [$clog2(QUEUE_ENTRIES)-1:0] selectedPtr,
    WakeupReleaseIF.queue rel,
    output logic dispatchReady,
    output logic [QUEUE_ENTRIES-1:0] readyVector,
    output SchedulerPkg::ActiveListPtr entryAlPtr [QUEUE_ENTRIES],
    output logic queueEmpty,
    output SchedulerPkg::OpTag issueTag
);

    localparam int INDEX_WIDTH = $clog2(QUEUE_ENTRIES);

    logic [QUEUE_ENTRIES-1:0] entryValid;
    logic [QUEUE_ENTRIES-1:0] entryIssued;
    SchedulerPkg::IssueOp entryOp [QUEUE_ENTRIES];
    // Row is the consumer, bit j means it still waits on entry j
    logic [QUEUE_ENTRIES-1:0] depMatrix [QUEUE_ENTRIES];

    logic [INDEX_WIDTH-1:0] allocPtr;
    logic allocate;
    logic [QUEUE_ENTRIES-1:0] releaseVector;
    logic [QUEUE_ENTRIES-1:0] wakeupColumn;
    logic [QUEUE_ENTRIES-1:0] flushMatch;

    // Scan from the top so the lowest free index is kept
    always_comb begin
        allocPtr = '0;
        for (int i = QUEUE_ENTRIES - 1; i >= 0; i--) begin
            if (!entryValid[i]) begin
                allocPtr = INDEX_WIDTH'(i);
            end
        end
    end

    assign dispatchReady = !(&entryValid);
    assign allocate = dispatchValid && dispatchReady && !(flushValid && flushAll);

    assign releaseVector = rel.releaseEntry ? (QUEUE_ENTRIES'(1) << rel.releasePtr) : '0;
    assign wakeupColumn = rel.wakeup ? rel.wakeupVector : '0;

    // Issued entries are left alone, their own release frees them
    always_comb begin
        for (int i = 0; i < QUEUE_ENTRIES; i++) begin
            flushMatch[i] = flushValid && entryValid[i] && !entryIssued[i]
                && (flushAll
                    || SchedulerPkg::InRange(entryOp[i].alPtr, flushHeadPtr, flushTailPtr));
        end
    end

    assign rel.flushIqEntry = flushMatch;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            entryValid <= '0;
            entryIssued <= '0;
        end else if (flushValid && flushAll) begin
            entryValid <= '0;
            entryIssued <= '0;
        end else begin
            for (int i = 0; i < QUEUE_ENTRIES; i++) begin
                if (flushMatch[i] || releaseVector[i]) begin
                    entryValid[i] <= 1'b0;
                    entryIssued[i] <= 1'b0;
                end
            end
            if (selected) begin
                entryIssued[selectedPtr] <= 1'b1;
            end
            if (allocate) begin
                entryValid[allocPtr] <= 1'b1;
                entryIssued[allocPtr] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < QUEUE_ENTRIES; i++) begin
            depMatrix[i] <= depMatrix[i] & ~wakeupColumn;
        end
        if (allocate) begin
            entryOp[allocPtr] <= '{tag: dispatchTag, alPtr: dispatchAlPtr};
            // Producers leaving at this edge are already done
            depMatrix[allocPtr] <= dispatchDepVector & entryValid & ~releaseVector;
        end
    end

    always_comb begin
        for (int i = 0; i < QUEUE_ENTRIES; i++) begin
            readyVector[i] = entryValid[i] && !entryIssued[i] && (depMatrix[i] == '0);
            entryAlPtr[i] = entryOp[i].alPtr;
        end
    end

    assign queueEmpty = ~|entryValid;
    assign issueTag = entryOp[selectedPtr].tag;

endmodule

//--- rtl/SchedulerTop.sv
/*
 * Scheduler slice top level
 * Selector, wakeup pipeline register and issue queue on plain ports
 */
module SchedulerTop #(
    parameter int QUEUE_ENTRIES = SchedulerPkg::QUEUE_ENTRIES_DEFAULT,
    parameter int WAKEUP_LATENCY = SchedulerPkg::WAKEUP_LATENCY_DEFAULT
) (
    input logic clk,
    input logic arstN,
    input logic stall,
    input logic dispatchValid,
    input SchedulerPkg::OpTag dispatchTag,
    input logic [QUEUE_ENTRIES-1:0] dispatchDepVector,
    input SchedulerPkg::ActiveListPtr dispatchAlPtr,
    input logic flushValid,
    input logic flushAll,
    input SchedulerPkg::ActiveListPtr flushHeadPtr,
    input SchedulerPkg::ActiveListPtr flushTailPtr,
    output logic dispatchReady,
    output logic issueValid,
    output logic [$clog2(QUEUE_ENTRIES)-1:0] issuePtr,
    output SchedulerPkg::OpTag issueTag,
    output logic wakeupValid,
    output logic [$clog2(QUEUE_ENTRIES)-1:0] wakeupPtr,
    output logic flushedOpExist
);

    logic [QUEUE_ENTRIES-1:0] readyVector;
    SchedulerPkg::ActiveListPtr entryAlPtr [QUEUE_ENTRIES];
    logic queueEmpty;

    WakeupSelectIF #(.QUEUE_ENTRIES(QUEUE_ENTRIES)) selIf ();
    WakeupReleaseIF #(.QUEUE_ENTRIES(QUEUE_ENTRIES)) relIf ();

    IssueSelector #(
        .QUEUE_ENTRIES(QUEUE_ENTRIES)
    ) selector (
        .clk(clk),
        .arstN(arstN),
        .stall(stall),
        .readyVector(readyVector),
        .entryAlPtr(entryAlPtr),
        .sel(selIf.selector),
        .queueEmpty(queueEmpty)
    );

    WakeupPipelineRegister #(
        .QUEUE_ENTRIES(QUEUE_ENTRIES),
        .WAKEUP_LATENCY(WAKEUP_LATENCY)
    ) wakeupPipe (
        .clk(clk),
        .arstN(arstN),
        .stall(stall),
        .flushValid(flushValid),
        .flushAll(flushAll),
        .flushHeadPtr(flushHeadPtr),
        .flushTailPtr(flushTailPtr),
        .sel(selIf.pipeline),
        .rel(relIf.pipeline),
        .flushedOpExist(flushedOpExist)
    );

    IssueQueue #(
        .QUEUE_ENTRIES(QUEUE_ENTRIES)
    ) queue (
        .clk(clk),
        .arstN(arstN),
        .dispatchValid(dispatchValid),
        .dispatchTag(dispatchTag),
        .dispatchDepVector(dispatchDepVector),
        .dispatchAlPtr(dispatchAlPtr),
        .flushValid(flushValid),
        .flushAll(flushAll),
        .flushHeadPtr(flushHeadPtr),
        .flushTailPtr(flushTailPtr),
        .selected(selIf.selected),
        .selectedPtr(selIf.selectedPtr),
        .rel(relIf.queue),
        .dispatchReady(dispatchReady),
        .readyVector(readyVector),
        .entryAlPtr(entryAlPtr),
        .queueEmpty(queueEmpty),
        .issueTag(issueTag)
    );

    assign issueValid = selIf.selected;
    assign issuePtr = selIf.selectedPtr;
    // The exiting op's entry is also the woken producer
    assign wakeupValid = relIf.wakeup;
    assign wakeupPtr = relIf.releasePtr;

endmodule

//--- test/Scheduler_sva.sv
/*
 * Concurrent checks on the wakeup pipeline register
 * and the bind that attaches them to every instance
 */
module SchedulerSva (
    input logic clk,
    input logic arstN,
    input logic stall,
    input logic flushValid,
    input logic flushAll,
    input logic wakeup,
    input logic releaseEntry,
    input logic flushedOpExist
);

    // A woken producer always gives back its entry
    wakeupNeedsRelease: assert property (
        @(posedge clk) disable iff (!arstN) wakeup |-> releaseEntry
    ) else $error("wakeup without a release");

    stallHoldsExit: assert property (
        @(posedge clk) disable iff (!arstN) stall |-> !wakeup && !releaseEntry
    ) else $error("wakeup or release while stalled");

    // Countdown is cleared along with the pipeline
    fullFlushClearsCount: assert property (
        @(posedge clk) disable iff (!arstN) flushValid && flushAll |=> !flushedOpExist
    ) else $error("flushedOpExist high after a full flush");

endmodule

bind WakeupPipelineRegister SchedulerSva sva (
    .clk(clk),
    .arstN(arstN),
    .stall(stall),
    .flushValid(flushValid),
    .flushAll(flushAll),
    .wakeup(rel.wakeup),
    .releaseEntry(rel.releaseEntry),
    .flushedOpExist(flushedOpExist)
);

//--- test/SchedulerTb.sv
/*
 * Directed testbench for the scheduler slice
 * Clock and reset, issue and wakeup monitor, dispatch and wait tasks,
 * value check and the six directed tests
 */
module SchedulerTb;

    localparam int LAT = SchedulerPkg::WAKEUP_LATENCY_DEFAULT;
    localparam int ENTRIES = SchedulerPkg::QUEUE_ENTRIES_DEFAULT;
    localparam int TIMEOUT = 50;
    localparam int STALL_CYCLES = 3;

    logic clk;
    logic arstN;
    logic stall;
    logic dispatchValid;
    SchedulerPkg::OpTag dispatchTag;
    logic [ENTRIES-1:0] dispatchDepVector;
    SchedulerPkg::ActiveListPtr dispatchAlPtr;
    logic flushValid;
    logic flushAll;
    SchedulerPkg::ActiveListPtr flushHeadPtr;
    SchedulerPkg::ActiveListPtr flushTailPtr;
    logic dispatchReady;
    logic issueValid;
    logic [$clog2(ENTRIES)-1:0] issuePtr;
    SchedulerPkg::OpTag issueTag;
    logic wakeupValid;
    logic [$clog2(ENTRIES)-1:0] wakeupPtr;
    logic flushedOpExist;

    int cycleCount = 0;
    int seed;
    int errorCount;
    int issueCycleQ [$];
    int issuePtrQ [$];
    int issueTagQ [$];
    int wakeCycleQ [$];
    int wakePtrQ [$];

    SchedulerTop dut (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    // Issue and wakeup events, stamped with the cycle they occur in
    always @(negedge clk) begin
        if (arstN) begin
            if (issueValid) begin
                issueCycleQ.push_back(cycleCount);
                issuePtrQ.push_back(int'(issuePtr));
                issueTagQ.push_back(int'(issueTag));
            end
            if (wakeupValid) begin
                wakeCycleQ.push_back(cycleCount);
                wakePtrQ.push_back(int'(wakeupPtr));
            end
        end
    end

    task automatic check(input string testName, input string what, input int expected,
                         input int actual);
        if (expected !== actual) begin
            errorCount++;
            $display("Fail %s: %s expected %0d actual %0d", testName, what, expected, actual);
            $display("Testbench failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Testbench failed");
        $fatal(1, "Stopped on timeout");
    endtask

    // Next rising edge plus the drive delay
    task automatic advance();
        @(posedge clk);
        #1;
    endtask

    function automatic int nextTag();
        return $random(seed) & 255;
    endfunction

    task automatic dispatchOp(input int tag, input logic [ENTRIES-1:0] dep, input int al);
        dispatchValid = 1'b1;
        dispatchTag = SchedulerPkg::OpTag'(tag);
        dispatchDepVector = dep;
        dispatchAlPtr = SchedulerPkg::ActiveListPtr'(al);
        advance();
        dispatchValid = 1'b0;
    endtask

    task automatic waitIssue(input string testName, output int issCycle, output int ptr,
                             output int tag);
        int waited;
        waited = 0;
        while (issueCycleQ.size() == 0) begin
            if (waited == TIMEOUT) begin
                reportTimeout({"an issue in the ", testName, " test"});
            end
            advance();
            waited++;
        end
        issCycle = issueCycleQ.pop_front();
        ptr = issuePtrQ.pop_front();
        tag = issueTagQ.pop_front();
    endtask

    task automatic waitWakeup(input string testName, output int wakeCycle, output int ptr);
        int waited;
        waited = 0;
        while (wakeCycleQ.size() == 0) begin
            if (waited == TIMEOUT) begin
                reportTimeout({"a wakeup in the ", testName, " test"});
            end
            advance();
            waited++;
        end
        wakeCycle = wakeCycleQ.pop_front();
        ptr = wakePtrQ.pop_front();
    endtask

    // Nothing left to issue or wake once the test has drained
    task automatic expectQuiet(input string testName, input int cycles);
        repeat (cycles) advance();
        check(testName, "extra issues", 0, issueCycleQ.size());
        check(testName, "extra wakeups", 0, wakeCycleQ.size());
    endtask

    task automatic resetState();
        check("reset", "issueValid", 0, issueValid);
        check("reset", "wakeupValid", 0, wakeupValid);
        check("reset", "flushedOpExist", 0, flushedOpExist);
        check("reset", "dispatchReady", 1, dispatchReady);
    endtask

    task automatic independentOps();
        int tags [4];
        int issCycle [4];
        int ptr;
        int tag;
        int wakeCycle;
        int k;
        for (k = 0; k < 4; k++) begin
            tags[k] = nextTag();
            dispatchOp(tags[k], '0, k);
        end
        for (k = 0; k < 4; k++) begin
            waitIssue("independent", issCycle[k], ptr, tag);
            check("independent", "issue pointer", k, ptr);
            check("independent", "issue tag", tags[k], tag);
        end
        for (k = 0; k < 4; k++) begin
            waitWakeup("independent", wakeCycle, ptr);
            check("independent", "wakeup cycle", issCycle[k] + LAT, wakeCycle);
            check("independent", "wakeup pointer", k, ptr);
        end
        expectQuiet("independent", 10);
    endtask

    task automatic dependencyChain();
        int tagA;
        int tagB;
        int issA;
        int issB;
        int ptr;
        int tag;
        int wakeCycle;
        tagA = nextTag();
        tagB = nextTag();
        dispatchOp(tagA, '0, 0);
        // B waits on entry 0, which holds A
        dispatchOp(tagB, ENTRIES'(1), 1);
        waitIssue("dependency", issA, ptr, tag);
        check("dependency", "producer pointer", 0, ptr);
        check("dependency", "producer tag", tagA, tag);
        waitIssue("dependency", issB, ptr, tag);
        check("dependency", "consumer pointer", 1, ptr);
        check("dependency", "consumer tag", tagB, tag);
        check("dependency", "consumer issue cycle", issA + LAT + 1, issB);
        waitWakeup("dependency", wakeCycle, ptr);
        check("dependency", "producer wakeup cycle", issA + LAT, wakeCycle);
        check("dependency", "producer wakeup pointer", 0, ptr);
        waitWakeup("dependency", wakeCycle, ptr);
        check("dependency", "consumer wakeup cycle", issB + LAT, wakeCycle);
        check("dependency", "consumer wakeup pointer", 1, ptr);
        expectQuiet("dependency", 10);
    endtask

    task automatic stallHold();
        int tagP;
        int tagQ;
        int issP;
        int issQ;
        int ptr;
        int tag;
        int wakeCycle;
        tagP = nextTag();
        tagQ = nextTag();
        dispatchOp(tagP, '0, 0);
        waitIssue("stall", issP, ptr, tag);
        check("stall", "issue pointer", 0, ptr);
        check("stall", "issue tag", tagP, tag);
        check("stall", "stall start cycle", issP + 1, cycleCount);
        // Second op arrives while stalled and must wait for the stall to end
        stall = 1'b1;
        dispatchOp(tagQ, '0, 1);
        repeat (STALL_CYCLES - 1) advance();
        stall = 1'b0;
        waitWakeup("stall", wakeCycle, ptr);
        check("stall", "wakeup cycle", issP + LAT + STALL_CYCLES, wakeCycle);
        check("stall", "wakeup pointer", 0, ptr);
        waitIssue("stall", issQ, ptr, tag);
        check("stall", "second issue cycle", issP + STALL_CYCLES + 1, issQ);
        check("stall", "second issue pointer", 1, ptr);
        check("stall", "second issue tag", tagQ, tag);
        waitWakeup("stall", wakeCycle, ptr);
        check("stall", "second wakeup cycle", issQ + LAT, wakeCycle);
        check("stall", "second wakeup pointer", 1, ptr);
        expectQuiet("stall", 10);
    endtask

    task automatic rangedFlush();
        int tags [6];
        int issCycle [4];
        int ptr;
        int tag;
        int wakeCycle;
        int k;
        stall = 1'b1;
        for (k = 0; k < 6; k++) begin
            tags[k] = nextTag();
            // Entries 4 and 5 wait on entry 3
            dispatchOp(tags[k], (k >= 4) ? (ENTRIES'(1) << 3) : '0, k);
        end
        stall = 1'b0;
        for (k = 0; k < 4; k++) begin
            waitIssue("ranged flush", issCycle[k], ptr, tag);
            check("ranged flush", "issue pointer", k, ptr);
            check("ranged flush", "issue tag", tags[k], tag);
        end
        // Entry 3 issued in the previous cycle and is still in flight
        check("ranged flush", "flush cycle", issCycle[3] + 1, cycleCount);
        flushValid = 1'b1;
        flushAll = 1'b0;
        flushHeadPtr = SchedulerPkg::ActiveListPtr'(3);
        flushTailPtr = SchedulerPkg::ActiveListPtr'(6);
        advance();
        flushValid = 1'b0;
        for (k = 0; k <= LAT; k++) begin
            #1;
            check("ranged flush", "flushedOpExist", k < LAT, flushedOpExist);
            advance();
        end
        for (k = 0; k < 3; k++) begin
            waitWakeup("ranged flush", wakeCycle, ptr);
            check("ranged flush", "wakeup cycle", issCycle[k] + LAT, wakeCycle);
            check("ranged flush", "wakeup pointer", k, ptr);
        end
        expectQuiet("ranged flush", 10);
    endtask

    task automatic fullFlush();
        int tags [ENTRIES];
        int issCycle;
        int ptr;
        int tag;
        int k;
        stall = 1'b1;
        for (k = 0; k < ENTRIES; k++) begin
            check("full flush", "dispatchReady while filling", 1, dispatchReady);
            tags[k] = nextTag();
            dispatchOp(tags[k], (k == 0) ? '0 : ENTRIES'(1), k);
        end
        check("full flush", "dispatchReady when full", 0, dispatchReady);
        // Ranged flush over unused pointers, its countdown holds while stalled
        flushValid = 1'b1;
        flushAll = 1'b0;
        flushHeadPtr = SchedulerPkg::ActiveListPtr'(8);
        flushTailPtr = SchedulerPkg::ActiveListPtr'(9);
        advance();
        flushValid = 1'b0;
        check("full flush", "flushedOpExist before flush", 1, flushedOpExist);
        stall = 1'b0;
        waitIssue("full flush", issCycle, ptr, tag);
        check("full flush", "issue pointer", 0, ptr);
        check("full flush", "issue tag", tags[0], tag);
        // Entry 0 is in flight, everything else waits on it
        flushValid = 1'b1;
        flushAll = 1'b1;
        advance();
        flushValid = 1'b0;
        flushAll = 1'b0;
        check("full flush", "dispatchReady after flush", 1, dispatchReady);
        check("full flush", "flushedOpExist after flush", 0, flushedOpExist);
        expectQuiet("full flush", 10);
    endtask

    initial begin
        seed = 61;
        errorCount = 0;
        clk = 1'b0;
        arstN = 1'b0;
        stall = 1'b0;
        dispatchValid = 1'b0;
        dispatchTag = '0;
        dispatchDepVector = '0;
        dispatchAlPtr = '0;
        flushValid = 1'b0;
        flushAll = 1'b0;
        flushHeadPtr = '0;
        flushTailPtr = '0;
        repeat (2) @(posedge clk);
        #1;
        arstN = 1'b1;
        resetState();
        independentOps();
        dependencyChain();
        stallHold();
        rangedFlush();
        fullFlush();
        if (errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- tb.f
rtl/SchedulerPkg.sv
rtl/WakeupSelectIF.sv
rtl/WakeupReleaseIF.sv
rtl/IssueSelector.sv
rtl/WakeupPipelineRegister.sv
rtl/IssueQueue.sv
rtl/SchedulerTop.sv
test/Scheduler_sva.sv
test/SchedulerTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the scheduler testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module SchedulerTb -f tb.f; then
    echo "Verilator build failed"
    exit 1
fi

simOutput=$(./obj_dir/VSchedulerTb 2>&1)
simStatus=$?
echo "$simOutput"

if [ "$simStatus" -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "Testbench passed" <<< "$simOutput"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1
